// File: verilog.f
sysBusPkg.sv
periphRegPkg.sv
sysBusDecoder.sv
ledSbCtrl.sv
ledBlinkGen.sv
swSbCtrl.sv
periphTop.sv
periphTop_sva.sv
periphTopTb.sv

// File: Makefile
TOP = periphTopTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: periphTopTb.sv
`timescale 1ns/100ps

module periphTopTb;

    localparam int BlinkHalf = 8;
    localparam int ClkPeriod = 40;
    localparam int NumRand = 16;
    localparam int NumModes = 8;
    // bus accesses and switch steps over all tests
    localparam int PlannedTrans = 4 + 2 * NumRand + 2 + 2 * NumModes + 8
                                  + 3 * NumRand + NumRand / 2 + 2 + 6;

    typedef logic [sysBusPkg::DataWidth-1:0] dataWord;

    logic                              clk;
    logic                              rst;
    logic                              req;
    logic                              writeEnable;
    logic [sysBusPkg::AddrWidth-1:0]   addr;
    dataWord                           writeData;
    dataWord                           readData;
    logic [periphRegPkg::LedWidth-1:0] sw;
    logic [periphRegPkg::LedWidth-1:0] led;

    // reference model state
    logic [periphRegPkg::LedWidth-1:0] mVal;
    logic                              mBlink;
    logic                              mSoftRst;
    int                                mCnt;
    logic                              mFlag;
    logic [periphRegPkg::LedWidth-1:0] mSwLast;
    dataWord                           ledRdLast;
    dataWord                           swRdLast;

    integer  seed;
    int      readErrors = 0;
    int      ledErrors = 0;
    dataWord d;
    dataWord r;

    periphTop #(
        .blinkHalf_p (BlinkHalf)
    ) dut0 (
        .clk_i         (clk),
        .rst_i         (rst),
        .req_i         (req),
        .writeEnable_i (writeEnable),
        .addr_i        (addr),
        .writeData_i   (writeData),
        .readData_o    (readData),
        .sw_i          (sw),
        .led_o         (led)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] ledAddr(input logic [23:0] off);
        return {sysBusPkg::SelLed, off};
    endfunction

    function automatic logic [31:0] swAddr(input logic [23:0] off);
        return {sysBusPkg::SelSw, off};
    endfunction

    function automatic logic [periphRegPkg::LedWidth-1:0] expectedLed();
        return (!mBlink || mCnt < BlinkHalf) ? mVal : '0;
    endfunction

    // model steps on every edge where the inputs are stable
    always @(posedge clk) begin
        if (rst) begin
            mVal = '0;
            mBlink = 1'b0;
            mSoftRst = 1'b0;
            mCnt = 0;
            mFlag = 1'b0;
            mSwLast = sw;
        end else begin
            // counter sees the mode from before the edge
            if (!mBlink || mSoftRst || mCnt == 2 * BlinkHalf - 1) begin
                mCnt = 0;
            end else begin
                mCnt = mCnt + 1;
            end
            mSoftRst = 1'b0;
            if (sw != mSwLast) begin
                mFlag = 1'b1;
            end
            mSwLast = sw;
            if (req && writeEnable && addr[31:24] == sysBusPkg::SelLed) begin
                if (addr[23:0] == periphRegPkg::OffValue && writeData[31:16] == '0) begin
                    mVal = writeData[15:0];
                end else if (addr[23:0] == periphRegPkg::OffMode
                             && writeData <= periphRegPkg::ModeMax) begin
                    mBlink = writeData[0];
                end else if (addr[23:0] == periphRegPkg::OffReset
                             && writeData == periphRegPkg::ResetKey) begin
                    mVal = '0;
                    mBlink = 1'b0;
                    mSoftRst = 1'b1;
                end
            end else if (req && writeEnable && addr[31:24] == sysBusPkg::SelSw
                         && addr[23:0] == periphRegPkg::OffReset
                         && writeData == periphRegPkg::ResetKey) begin
                mFlag = 1'b0;
            end
        end
    end

    // led output checked every cycle in the low clock phase
    always @(negedge clk) begin
        if (!rst) begin
            assert (led == expectedLed()) else begin
                $display("FAILED at %0t: led_o is %h, expected %h", $time, led, expectedLed());
                ledErrors++;
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic busWrite(input logic [31:0] a, input dataWord data);
        req = 1'b1;
        writeEnable = 1'b1;
        addr = a;
        writeData = data;
        @(posedge clk);
        #2;
        req = 1'b0;
        writeEnable = 1'b0;
    endtask

    task automatic busRead(input logic [31:0] a);
        dataWord exp;
        if (a[31:24] == sysBusPkg::SelLed) begin
            if (a[23:0] == periphRegPkg::OffValue) begin
                ledRdLast = dataWord'(mVal);
            end else if (a[23:0] == periphRegPkg::OffMode) begin
                ledRdLast = dataWord'(mBlink);
            end
            exp = ledRdLast;
        end else if (a[31:24] == sysBusPkg::SelSw) begin
            if (a[23:0] == periphRegPkg::OffValue) begin
                swRdLast = dataWord'(sw);
            end else if (a[23:0] == periphRegPkg::OffMode) begin
                swRdLast = dataWord'(mFlag);
            end
            exp = swRdLast;
        end else begin
            exp = '0;
        end
        req = 1'b1;
        writeEnable = 1'b0;
        addr = a;
        writeData = $random(seed);
        @(posedge clk);
        #2;
        req = 1'b0;
        assert (readData == exp) else begin
            $display("FAILED at %0t: read of %h returned %h, expected %h",
                     $time, a, readData, exp);
            readErrors++;
        end
    endtask

    // switches settle through the synchronizer before any read
    task automatic changeSwitches(input logic [periphRegPkg::LedWidth-1:0] v);
        sw = v;
        idle(5);
    endtask

    initial begin
        seed = 32'h9f0d;
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        writeEnable = 1'b0;
        addr = '0;
        writeData = '0;
        sw = '0;
        ledRdLast = '0;
        swRdLast = '0;
        idle(5);
        rst = 1'b0;

        busRead(ledAddr(periphRegPkg::OffValue));
        busRead(ledAddr(periphRegPkg::OffMode));
        busRead(swAddr(periphRegPkg::OffValue));
        busRead(swAddr(periphRegPkg::OffMode));

        // about a third of the value writes carry upper bits and get dropped
        for (int i = 0; i < NumRand; i++) begin
            d = $random(seed);
            if ($random(seed) % 3 != 0) begin
                d[31:16] = '0;
            end
            busWrite(ledAddr(periphRegPkg::OffValue), d);
            busRead(ledAddr(periphRegPkg::OffValue));
        end

        busWrite(ledAddr(periphRegPkg::OffValue), 32'h0000_c3a5);
        busRead(ledAddr(periphRegPkg::OffValue));
        for (int i = 0; i < NumModes; i++) begin
            d = $random(seed) & 32'h3;
            busWrite(ledAddr(periphRegPkg::OffMode), d);
            idle(2 * BlinkHalf + 3);
            busRead(ledAddr(periphRegPkg::OffMode));
        end

        busWrite(ledAddr(periphRegPkg::OffValue), 32'h0000_a5a5);
        busWrite(ledAddr(periphRegPkg::OffMode), 32'h1);
        idle(5);
        d = $random(seed) | 32'h2;
        busWrite(ledAddr(periphRegPkg::OffReset), d);
        busRead(ledAddr(periphRegPkg::OffValue));
        busRead(ledAddr(periphRegPkg::OffMode));
        busWrite(ledAddr(periphRegPkg::OffReset), periphRegPkg::ResetKey);
        idle(3);
        busRead(ledAddr(periphRegPkg::OffValue));
        busRead(ledAddr(periphRegPkg::OffMode));

        for (int i = 0; i < NumRand; i++) begin
            r = $random(seed);
            changeSwitches(r[15:0]);
            busRead(swAddr(periphRegPkg::OffValue));
            busRead(swAddr(periphRegPkg::OffMode));
            if (i % 4 == 3) begin
                busWrite(swAddr(periphRegPkg::OffReset), periphRegPkg::ResetKey);
                busRead(swAddr(periphRegPkg::OffMode));
            end
        end
        busWrite(swAddr(periphRegPkg::OffReset), periphRegPkg::ResetKey);
        busRead(swAddr(periphRegPkg::OffMode));

        // unmapped offsets keep the last read and an unmapped peripheral reads zero
        busWrite(ledAddr(periphRegPkg::OffValue), 32'h0000_5a3c);
        busRead(ledAddr(periphRegPkg::OffValue));
        busRead(ledAddr(24'h10));
        busRead(swAddr(periphRegPkg::OffValue));
        busRead(swAddr(24'h08));
        busRead(32'h0700_0000);

        $display("errors: %0d read, %0d led", readErrors, ledErrors);
        if (readErrors + ledErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(PlannedTrans * 10 * ClkPeriod);
        $display("ERROR: watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: periphTop_sva.sv
`timescale 1ns/100ps

module periphTopProps (
    input logic                              clk_i,
    input logic                              rst_i,
    input logic                              req_i,
    input logic                              writeEnable_i,
    input logic [sysBusPkg::DataWidth-1:0]   readData_i,
    input logic [periphRegPkg::LedWidth-1:0] led_i,
    input logic [periphRegPkg::LedWidth-1:0] ledVal_i,
    input logic                              blinkOn_i,
    input logic                              ledReq_i,
    input logic                              swReq_i
);

    // decoder selects at most one peripheral
    onePeriph: assert property (@(posedge clk_i) disable iff (rst_i)
        !(ledReq_i && swReq_i))
        else $error("led and switch requests active in the same cycle");

    readHold: assert property (@(posedge clk_i) disable iff (rst_i)
        !(req_i && !writeEnable_i) |=> $stable(readData_i))
        else $error("read data changed without a read");

    // led value passes straight through while blinking is off
    ledPass: assert property (@(posedge clk_i) disable iff (rst_i)
        !blinkOn_i |-> (led_i == ledVal_i))
        else $error("led output differs from the led value with blinking off");

endmodule

bind periphTop periphTopProps sva0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .writeEnable_i (writeEnable_i),
    .readData_i    (readData_o),
    .led_i         (led_o),
    .ledVal_i      (ledVal),
    .blinkOn_i     (blinkOn),
    .ledReq_i      (ledReq),
    .swReq_i       (swReq)
);

// File: periphTop.sv
`timescale 1ns/100ps

module periphTop #(
    parameter int blinkHalf_p = periphRegPkg::BlinkHalfDefault
) (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 req_i,
    input  logic                                 writeEnable_i,
    input  logic [sysBusPkg::AddrWidth-1:0]      addr_i,
    input  logic [sysBusPkg::DataWidth-1:0]      writeData_i,
    output logic [sysBusPkg::DataWidth-1:0]      readData_o,
    input  logic [periphRegPkg::LedWidth-1:0]    sw_i,
    output logic [periphRegPkg::LedWidth-1:0]    led_o
);

    logic                              ledReq;
    logic                              swReq;
    logic [sysBusPkg::OffsetWidth-1:0] offset;
    logic [sysBusPkg::DataWidth-1:0]   ledReadData;
    logic [sysBusPkg::DataWidth-1:0]   swReadData;
    logic [periphRegPkg::LedWidth-1:0] ledVal;
    logic                              blinkOn;
    logic                              softRst;

    sysBusDecoder decoder0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .writeEnable_i (writeEnable_i),
        .addr_i        (addr_i),
        .ledReadData_i (ledReadData),
        .swReadData_i  (swReadData),
        .ledReq_o      (ledReq),
        .swReq_o       (swReq),
        .offset_o      (offset),
        .readData_o    (readData_o)
    );

    ledSbCtrl ledCtrl0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (ledReq),
        .writeEnable_i (writeEnable_i),
        .offset_i      (offset),
        .writeData_i   (writeData_i),
        .readData_o    (ledReadData),
        .ledVal_o      (ledVal),
        .blinkOn_o     (blinkOn),
        .softRst_o     (softRst)
    );

    ledBlinkGen #(
        .blinkHalf_p (blinkHalf_p)
    ) blink0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .ledVal_i  (ledVal),
        .blinkOn_i (blinkOn),
        .softRst_i (softRst),
        .led_o     (led_o)
    );

    swSbCtrl swCtrl0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (swReq),
        .writeEnable_i (writeEnable_i),
        .offset_i      (offset),
        .writeData_i   (writeData_i),
        .sw_i          (sw_i),
        .readData_o    (swReadData)
    );

endmodule

// File: swSbCtrl.sv
`timescale 1ns/100ps

module swSbCtrl (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 req_i,
    input  logic                                 writeEnable_i,
    input  logic [sysBusPkg::OffsetWidth-1:0]    offset_i,
    input  logic [sysBusPkg::DataWidth-1:0]      writeData_i,
    input  logic [periphRegPkg::LedWidth-1:0]    sw_i,
    output logic [sysBusPkg::DataWidth-1:0]      readData_o
);

    logic [periphRegPkg::LedWidth-1:0] swMeta;
    logic [periphRegPkg::LedWidth-1:0] swSync;
    logic [periphRegPkg::LedWidth-1:0] swPrev;
    logic                              changeFlag;
    logic                              rdReq;
    logic                              flagClr;

    assign rdReq   = req_i & ~writeEnable_i;
    assign flagClr = req_i && writeEnable_i && (offset_i == periphRegPkg::OffReset)
                     && (writeData_i == periphRegPkg::ResetKey);

    // two stage synchronizer plus a copy for edge detection
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            swMeta <= '0;
            swSync <= '0;
            swPrev <= '0;
        end else begin
            swMeta <= sw_i;
            swSync <= swMeta;
            swPrev <= swSync;
        end
    end

    // sticky until cleared by the reset key
    always_ff @(posedge clk_i) begin
        if (rst_i || flagClr) begin
            changeFlag <= 1'b0;
        end else if (swSync != swPrev) begin
            changeFlag <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            readData_o <= '0;
        end else if (rdReq && (offset_i == periphRegPkg::OffValue)) begin
            readData_o <= {{(sysBusPkg::DataWidth-periphRegPkg::LedWidth){1'b0}}, swSync};
        end else if (rdReq && (offset_i == periphRegPkg::OffMode)) begin
            readData_o <= {{(sysBusPkg::DataWidth-1){1'b0}}, changeFlag};
        end
    end

endmodule

// File: ledBlinkGen.sv
`timescale 1ns/100ps

module ledBlinkGen #(
    parameter int blinkHalf_p = periphRegPkg::BlinkHalfDefault
) (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic [periphRegPkg::LedWidth-1:0]    ledVal_i,
    input  logic                                 blinkOn_i,
    input  logic                                 softRst_i,
    output logic [periphRegPkg::LedWidth-1:0]    led_o
);

    localparam int CntWidth = $clog2(2 * blinkHalf_p);

    localparam logic [CntWidth-1:0] HalfCnt = CntWidth'(blinkHalf_p);
    localparam logic [CntWidth-1:0] LastCnt = CntWidth'(2 * blinkHalf_p - 1);

    logic [CntWidth-1:0] blinkCnt;

    // counter sits at zero while blinking is off
    always_ff @(posedge clk_i) begin
        if (rst_i || softRst_i || !blinkOn_i) begin
            blinkCnt <= '0;
        end else if (blinkCnt == LastCnt) begin
            blinkCnt <= '0;
        end else begin
            blinkCnt <= blinkCnt + 1'b1;
        end
    end

    // lit in the first half of the period and whenever blinking is off
    assign led_o = (!blinkOn_i || blinkCnt < HalfCnt) ? ledVal_i : '0;

endmodule

// File: ledSbCtrl.sv
`timescale 1ns/100ps

module ledSbCtrl (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 req_i,
    input  logic                                 writeEnable_i,
    input  logic [sysBusPkg::OffsetWidth-1:0]    offset_i,
    input  logic [sysBusPkg::DataWidth-1:0]      writeData_i,
    output logic [sysBusPkg::DataWidth-1:0]      readData_o,
    output logic [periphRegPkg::LedWidth-1:0]    ledVal_o,
    output logic                                 blinkOn_o,
    output logic                                 softRst_o
);

    logic wrReq;
    logic rdReq;
    logic hitValue;
    logic hitMode;
    logic hitReset;
    logic valueOk;
    logic modeOk;
    logic resetHit;

    assign wrReq = req_i & writeEnable_i;
    assign rdReq = req_i & ~writeEnable_i;

    assign hitValue = (offset_i == periphRegPkg::OffValue);
    assign hitMode  = (offset_i == periphRegPkg::OffMode);
    assign hitReset = (offset_i == periphRegPkg::OffReset);

    // value only fits in the low half of the word
    assign valueOk  = (writeData_i[sysBusPkg::DataWidth-1:periphRegPkg::LedWidth] == '0);
    assign modeOk   = (writeData_i <= periphRegPkg::ModeMax);
    assign resetHit = wrReq && hitReset && (writeData_i == periphRegPkg::ResetKey);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ledVal_o  <= '0;
            blinkOn_o <= 1'b0;
        end else if (resetHit) begin
            ledVal_o  <= '0;
            blinkOn_o <= 1'b0;
        end else if (wrReq) begin
            if (hitValue && valueOk) begin
                ledVal_o <= writeData_i[periphRegPkg::LedWidth-1:0];
            end
            if (hitMode && modeOk) begin
                blinkOn_o <= writeData_i[0];
            end
        end
    end

    // one cycle pulse toward the blink generator
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            softRst_o <= 1'b0;
        end else begin
            softRst_o <= resetHit;
        end
    end

    // unmapped offsets keep the previous read data
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            readData_o <= '0;
        end else if (rdReq && hitValue) begin
            readData_o <= {{(sysBusPkg::DataWidth-periphRegPkg::LedWidth){1'b0}}, ledVal_o};
        end else if (rdReq && hitMode) begin
            readData_o <= {{(sysBusPkg::DataWidth-1){1'b0}}, blinkOn_o};
        end
    end

endmodule

// File: sysBusDecoder.sv
`timescale 1ns/100ps

module sysBusDecoder (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 req_i,
    input  logic                                 writeEnable_i,
    input  logic [sysBusPkg::AddrWidth-1:0]      addr_i,
    input  logic [sysBusPkg::DataWidth-1:0]      ledReadData_i,
    input  logic [sysBusPkg::DataWidth-1:0]      swReadData_i,
    output logic                                 ledReq_o,
    output logic                                 swReq_o,
    output logic [sysBusPkg::OffsetWidth-1:0]    offset_o,
    output logic [sysBusPkg::DataWidth-1:0]      readData_o
);

    logic [sysBusPkg::PeriphSelWidth-1:0] periphSel;
    logic [sysBusPkg::PeriphSelWidth-1:0] rdSel;
    logic                                 rdReq;

    // peripheral number sits in the top address byte
    assign periphSel = addr_i[sysBusPkg::AddrWidth-1 -: sysBusPkg::PeriphSelWidth];
    assign offset_o  = addr_i[sysBusPkg::OffsetWidth-1:0];

    assign ledReq_o = req_i && (periphSel == sysBusPkg::SelLed);
    assign swReq_o  = req_i && (periphSel == sysBusPkg::SelSw);

    assign rdReq = req_i & ~writeEnable_i;

    // remember where the last read went, the data itself is registered
    // inside each peripheral
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdSel <= '0;
        end else if (rdReq) begin
            rdSel <= periphSel;
        end
    end

    always_comb begin
        case (rdSel)
            sysBusPkg::SelLed: readData_o = ledReadData_i;
            sysBusPkg::SelSw:  readData_o = swReadData_i;
            // unmapped peripheral number reads as zero
            default:           readData_o = '0;
        endcase
    end

endmodule

// File: periphRegPkg.sv
package periphRegPkg;

    // register offsets inside a peripheral
    localparam logic [sysBusPkg::OffsetWidth-1:0] OffValue = 24'h00;
    localparam logic [sysBusPkg::OffsetWidth-1:0] OffMode  = 24'h04;
    localparam logic [sysBusPkg::OffsetWidth-1:0] OffReset = 24'h24;

    // data word that triggers the soft reset
    localparam logic [sysBusPkg::DataWidth-1:0] ResetKey = 32'd1;

    // largest word the mode register takes
    localparam logic [sysBusPkg::DataWidth-1:0] ModeMax = 32'd1;

    // number of leds, also number of switches
    localparam int LedWidth = 16;

    // blink half period in clock cycles
    localparam int BlinkHalfDefault = 10_000_000;

endpackage

// File: sysBusPkg.sv
package sysBusPkg;

    // system bus widths
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;

    // low address part handed to the peripheral
    localparam int OffsetWidth = 24;

    // peripheral number lives in address bits 31..24
    localparam int PeriphSelWidth = 8;

    // peripheral select encoding
    localparam logic [PeriphSelWidth-1:0] SelSw  = 8'd1;
    localparam logic [PeriphSelWidth-1:0] SelLed = 8'd2;

endpackage
